/* hdl/fetch_bus_pkg.sv */
package fetch_bus_pkg;

    typedef logic [63:0] addr_t;  // bus address, both sides
    typedef logic [31:0] word_t;  // fetch side data word
    typedef logic [63:0] beat_t;  // memory side data beat
    typedef logic [3:0]  mask_t;  // byte write enables

endpackage

/* hdl/route_pkg.sv */
package route_pkg;

    typedef enum logic [1:0] {
        IDLE,      // nothing in flight, next command picks the path
        CACHED,    // commands go to the cache core
        UNCACHED   // commands go straight to memory
    } route_state_e;

    typedef logic [3:0] pending_t;  // outstanding responses, also lane fifo index

    // uncached window, both bounds inclusive
    localparam fetch_bus_pkg::addr_t UNCACHED_BASE_DEF  = 64'h0000_0000_0000_0000;
    localparam fetch_bus_pkg::addr_t UNCACHED_LIMIT_DEF = 64'h0000_0000_0000_0014;

endpackage

/* hdl/path_router.sv */
`timescale 1ns/100ps

module path_router #(
    parameter fetch_bus_pkg::addr_t UNCACHED_BASE  = route_pkg::UNCACHED_BASE_DEF,
    parameter fetch_bus_pkg::addr_t UNCACHED_LIMIT = route_pkg::UNCACHED_LIMIT_DEF
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 core_cmd_valid,
    input  logic                 core_cmd_ready,      // merged ready from bus_merge
    input  fetch_bus_pkg::addr_t core_cmd_addr,
    input  logic                 core_rsp_valid,      // merged response valid
    input  logic                 cache_idle,          // cache core has no burst running
    output logic                 uncached_sel,
    output logic                 cached_req_valid,
    output logic                 uncached_req_valid
);

    import route_pkg::*;

    route_state_e state_q;
    route_state_e state_d;
    pending_t     pending_q;
    logic         in_window;
    logic         cmd_accept;
    logic         cnt_inc;
    logic         cnt_dec;
    logic         drained;

    //////////////////////////////////////////////////////////////////////
    // window decode and path select
    //////////////////////////////////////////////////////////////////////

    assign in_window = (core_cmd_addr >= UNCACHED_BASE) && (core_cmd_addr <= UNCACHED_LIMIT);

    assign uncached_sel = (state_q == UNCACHED) ||
                          ((state_q == IDLE) && core_cmd_valid && in_window);

    // a command for the inactive path raises neither request, so it waits
    assign cached_req_valid   = core_cmd_valid & ~in_window & ~uncached_sel;
    assign uncached_req_valid = core_cmd_valid & in_window & uncached_sel;

    //////////////////////////////////////////////////////////////////////
    // routing FSM
    //////////////////////////////////////////////////////////////////////

    assign drained = (pending_q == '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cached_req_valid) begin
                    state_d = CACHED;
                end else if (uncached_req_valid) begin
                    state_d = UNCACHED;
                end
            end
            CACHED: begin
                // cache core may still be refilling after the last response
                if (!cached_req_valid && drained && cache_idle) begin
                    state_d = IDLE;
                end
            end
            UNCACHED: begin
                if (!uncached_req_valid && drained) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outstanding response counter
    //////////////////////////////////////////////////////////////////////

    assign cmd_accept = core_cmd_valid & core_cmd_ready;
    assign cnt_inc    = cmd_accept & ~core_rsp_valid;
    assign cnt_dec    = core_rsp_valid & ~cmd_accept;  // both at once, no change

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pending_q <= '0;
        end else if (cnt_inc) begin
            pending_q <= pending_q + 1'b1;
        end else if (cnt_dec) begin
            pending_q <= pending_q - 1'b1;
        end
    end

    // responses must match earlier commands, and the lane fifo must not overflow
    assert property (@(posedge clk) disable iff (!rstn)
        !(cnt_dec && pending_q == '0) && !(cnt_inc && pending_q == '1))
        else $error("path_router: pending count out of range");

endmodule

/* hdl/uncached_lane_fifo.sv */
`timescale 1ns/100ps

module uncached_lane_fifo (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 uncached_sel,
    input  logic                 core_cmd_valid,
    input  logic                 core_cmd_ready,
    input  fetch_bus_pkg::addr_t core_cmd_addr,
    input  logic                 core_rsp_valid,
    input  logic                 mem_rsp_valid,
    input  fetch_bus_pkg::beat_t mem_rsp_rdata,
    input  logic                 mem_rsp_err,
    output logic                 uncached_rsp_valid,
    output fetch_bus_pkg::word_t uncached_rsp_rdata,
    output logic                 uncached_rsp_err
);

    import fetch_bus_pkg::*;
    import route_pkg::*;

    localparam int DEPTH  = 2 ** $bits(pending_t);
    localparam int WORD_W = $bits(word_t);

    logic     lane_mem [DEPTH];  // address bit 2 of each uncached command
    pending_t wr_ptr;
    pending_t rd_ptr;
    logic     push;
    logic     pop;
    logic     fifo_empty;
    beat_t    beat_q;            // last uncached memory beat

    //////////////////////////////////////////////////////////////////////
    // lane select fifo
    //////////////////////////////////////////////////////////////////////

    assign push       = uncached_sel & core_cmd_valid & core_cmd_ready;
    assign pop        = uncached_sel & core_rsp_valid;
    assign fifo_empty = (wr_ptr == rd_ptr);

    always_ff @(posedge clk) begin
        if (push) begin
            lane_mem[wr_ptr] <= core_cmd_addr[2];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered response
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            uncached_rsp_valid <= 1'b0;
            uncached_rsp_err   <= 1'b0;
        end else begin
            uncached_rsp_valid <= uncached_sel & mem_rsp_valid;
            uncached_rsp_err   <= uncached_sel & mem_rsp_valid & mem_rsp_err;
        end
    end

    always_ff @(posedge clk) begin
        if (uncached_sel && mem_rsp_valid) begin
            beat_q <= mem_rsp_rdata;
        end
    end

    // head entry belongs to the response now on the output
    assign uncached_rsp_rdata = lane_mem[rd_ptr] ? beat_q[2*WORD_W-1:WORD_W]
                                                 : beat_q[WORD_W-1:0];

    assert property (@(posedge clk) disable iff (!rstn) pop |-> !fifo_empty)
        else $error("uncached_lane_fifo: response with no lane entry");

endmodule

/* hdl/bus_merge.sv */
`timescale 1ns/100ps

module bus_merge (
    input  logic                 uncached_sel,
    input  logic                 cached_req_valid,
    input  logic                 uncached_req_valid,
    // fetch side command
    input  fetch_bus_pkg::addr_t core_cmd_addr,
    input  logic                 core_cmd_read,
    input  fetch_bus_pkg::word_t core_cmd_wdata,
    input  fetch_bus_pkg::mask_t core_cmd_wmask,
    // cache core fetch port
    input  logic                 cache_cmd_ready,
    input  logic                 cache_rsp_valid,
    input  fetch_bus_pkg::word_t cache_rsp_rdata,
    input  logic                 cache_rsp_err,
    // cache core memory port
    input  logic                 cmem_cmd_valid,
    input  fetch_bus_pkg::addr_t cmem_cmd_addr,
    input  logic                 cmem_cmd_read,
    input  fetch_bus_pkg::beat_t cmem_cmd_wdata,
    input  fetch_bus_pkg::mask_t cmem_cmd_wmask,
    // memory bus
    input  logic                 mem_cmd_ready,
    input  logic                 mem_rsp_valid,
    input  fetch_bus_pkg::beat_t mem_rsp_rdata,
    input  logic                 mem_rsp_err,
    // registered uncached response
    input  logic                 uncached_rsp_valid,
    input  fetch_bus_pkg::word_t uncached_rsp_rdata,
    input  logic                 uncached_rsp_err,
    output logic                 cache_cmd_valid,
    output logic                 core_cmd_ready,
    output logic                 core_rsp_valid,
    output fetch_bus_pkg::word_t core_rsp_rdata,
    output logic                 core_rsp_err,
    output logic                 cmem_cmd_ready,
    output logic                 cmem_rsp_valid,
    output fetch_bus_pkg::beat_t cmem_rsp_rdata,
    output logic                 cmem_rsp_err,
    output logic                 mem_cmd_valid,
    output fetch_bus_pkg::addr_t mem_cmd_addr,
    output logic                 mem_cmd_read,
    output fetch_bus_pkg::beat_t mem_cmd_wdata,
    output fetch_bus_pkg::mask_t mem_cmd_wmask
);

    import fetch_bus_pkg::*;

    beat_t uc_wdata;

    assign uc_wdata = beat_t'(core_cmd_wdata);  // zero extend to beat width

    //////////////////////////////////////////////////////////////////////
    // command side
    //////////////////////////////////////////////////////////////////////

    assign cache_cmd_valid = cached_req_valid;
    assign mem_cmd_valid   = uncached_req_valid | cmem_cmd_valid;

    assign core_cmd_ready = uncached_sel ? (mem_cmd_ready & uncached_req_valid)
                                         : (cache_cmd_ready & cached_req_valid);

    always_comb begin
        if (uncached_sel) begin
            mem_cmd_addr  = core_cmd_addr;
            mem_cmd_read  = core_cmd_read;
            mem_cmd_wdata = uc_wdata;
            mem_cmd_wmask = core_cmd_wmask;
        end else begin
            mem_cmd_addr  = cmem_cmd_addr;
            mem_cmd_read  = cmem_cmd_read;
            mem_cmd_wdata = cmem_cmd_wdata;
            mem_cmd_wmask = cmem_cmd_wmask;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response side
    //////////////////////////////////////////////////////////////////////

    assign cmem_cmd_ready = mem_cmd_ready & ~uncached_sel;  // cache core sees no memory
    assign cmem_rsp_valid = mem_rsp_valid & ~uncached_sel;
    assign cmem_rsp_rdata = mem_rsp_rdata;
    assign cmem_rsp_err   = mem_rsp_err;

    assign core_rsp_valid = uncached_sel ? uncached_rsp_valid : cache_rsp_valid;
    assign core_rsp_rdata = uncached_sel ? uncached_rsp_rdata : cache_rsp_rdata;
    assign core_rsp_err   = uncached_sel ? uncached_rsp_err : cache_rsp_err;

    // the router drains the cache core before any uncached command is raised
    always_comb begin
        assert final (!(uncached_req_valid && cmem_cmd_valid))
            else $error("bus_merge: memory command from both paths");
    end

endmodule

/* hdl/fetch_cache_front.sv */
`timescale 1ns/100ps

module fetch_cache_front #(
    parameter fetch_bus_pkg::addr_t UNCACHED_BASE  = route_pkg::UNCACHED_BASE_DEF,
    parameter fetch_bus_pkg::addr_t UNCACHED_LIMIT = route_pkg::UNCACHED_LIMIT_DEF
) (
    input  logic                 clk,
    input  logic                 rstn,
    // fetch unit
    input  logic                 core_cmd_valid,
    output logic                 core_cmd_ready,
    input  fetch_bus_pkg::addr_t core_cmd_addr,
    input  logic                 core_cmd_read,
    input  fetch_bus_pkg::word_t core_cmd_wdata,
    input  fetch_bus_pkg::mask_t core_cmd_wmask,
    output logic                 core_rsp_valid,
    input  logic                 core_rsp_ready,
    output fetch_bus_pkg::word_t core_rsp_rdata,
    output logic                 core_rsp_err,
    // cache core fetch port
    output logic                 cache_cmd_valid,
    input  logic                 cache_cmd_ready,
    output fetch_bus_pkg::addr_t cache_cmd_addr,
    output logic                 cache_cmd_read,
    output fetch_bus_pkg::word_t cache_cmd_wdata,
    output fetch_bus_pkg::mask_t cache_cmd_wmask,
    input  logic                 cache_rsp_valid,
    output logic                 cache_rsp_ready,
    input  fetch_bus_pkg::word_t cache_rsp_rdata,
    input  logic                 cache_rsp_err,
    input  logic                 cache_idle,
    // cache core memory port
    input  logic                 cmem_cmd_valid,
    output logic                 cmem_cmd_ready,
    input  fetch_bus_pkg::addr_t cmem_cmd_addr,
    input  logic                 cmem_cmd_read,
    input  fetch_bus_pkg::beat_t cmem_cmd_wdata,
    input  fetch_bus_pkg::mask_t cmem_cmd_wmask,
    output logic                 cmem_rsp_valid,
    output fetch_bus_pkg::beat_t cmem_rsp_rdata,
    output logic                 cmem_rsp_err,
    // memory bus
    output logic                 mem_cmd_valid,
    input  logic                 mem_cmd_ready,
    output fetch_bus_pkg::addr_t mem_cmd_addr,
    output logic                 mem_cmd_read,
    output fetch_bus_pkg::beat_t mem_cmd_wdata,
    output fetch_bus_pkg::mask_t mem_cmd_wmask,
    input  logic                 mem_rsp_valid,
    input  fetch_bus_pkg::beat_t mem_rsp_rdata,
    input  logic                 mem_rsp_err
);

    import fetch_bus_pkg::*;

    logic  uncached_sel;
    logic  cached_req_valid;
    logic  uncached_req_valid;
    logic  uncached_rsp_valid;
    word_t uncached_rsp_rdata;
    logic  uncached_rsp_err;

    // cache core command fields come straight from the fetch unit
    assign cache_cmd_addr  = core_cmd_addr;
    assign cache_cmd_read  = core_cmd_read;
    assign cache_cmd_wdata = core_cmd_wdata;
    assign cache_cmd_wmask = core_cmd_wmask;
    assign cache_rsp_ready = core_rsp_ready;

    path_router #(
        .UNCACHED_BASE  (UNCACHED_BASE),
        .UNCACHED_LIMIT (UNCACHED_LIMIT)
    ) u_path_router (.*);

    uncached_lane_fifo u_uncached_lane_fifo (.*);  // lane select, registered rsp

    bus_merge u_bus_merge (.*);

endmodule

/* dv/tb_tasks.svh */
// values seen in the cycle a command was accepted
logic  cap_cache_valid;
addr_t cap_cache_addr;
logic  cap_cache_read;
word_t cap_cache_wdata;
mask_t cap_cache_wmask;
logic  cap_mem_valid;
addr_t cap_mem_addr;
logic  cap_mem_read;
beat_t cap_mem_wdata;
mask_t cap_mem_wmask;

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act) begin
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_beat(string name, beat_t exp, beat_t act);
    if (exp !== act) begin
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_addr(string name, addr_t exp, addr_t act);
    if (exp !== act) begin
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_mask(string name, mask_t exp, mask_t act);
    if (exp !== act) begin
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
        $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
        errors++;
    end
endtask

//////////////////////////////////////////////////////////////////////
// bus helpers
//////////////////////////////////////////////////////////////////////

// returns at the accepting edge, valid stays up for back to back use
task automatic issue_cmd(addr_t a, logic rd, word_t wd, mask_t wm);
    int n;
    n = 0;
    @(negedge clk);
    core_cmd_valid = 1'b1;
    core_cmd_addr  = a;
    core_cmd_read  = rd;
    core_cmd_wdata = wd;
    core_cmd_wmask = wm;
    do begin
        @(posedge clk);
        n++;
    end while (!core_cmd_ready && n < MAX_WAIT);
    if (!core_cmd_ready) begin
        $display("error at %0t: command to %h never accepted", $time, a);
        errors++;
    end
    cap_cache_valid = cache_cmd_valid;
    cap_cache_addr  = cache_cmd_addr;
    cap_cache_read  = cache_cmd_read;
    cap_cache_wdata = cache_cmd_wdata;
    cap_cache_wmask = cache_cmd_wmask;
    cap_mem_valid   = mem_cmd_valid;
    cap_mem_addr    = mem_cmd_addr;
    cap_mem_read    = mem_cmd_read;
    cap_mem_wdata   = mem_cmd_wdata;
    cap_mem_wmask   = mem_cmd_wmask;
endtask

task automatic release_cmd();
    @(negedge clk);
    core_cmd_valid = 1'b0;
endtask

task automatic wait_rsp(output word_t rd, output logic err, output logic mem_prev);
    int n;
    logic prev;
    n = 0;
    prev = 1'b0;
    forever begin
        @(posedge clk);
        if (core_rsp_valid) begin
            break;
        end
        prev = mem_rsp_valid;
        n++;
        if (n >= MAX_WAIT) begin
            $display("error at %0t: no response on the fetch side", $time);
            errors++;
            break;
        end
    end
    rd = core_rsp_rdata;
    err = core_rsp_err;
    mem_prev = prev;
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset_idle();
    repeat (5) begin
        @(posedge clk);
        check_bit("core_rsp_valid", 1'b0, core_rsp_valid);
        check_bit("mem_cmd_valid", 1'b0, mem_cmd_valid);
    end
endtask

task automatic test_cached_read();
    addr_t a;
    word_t rd;
    logic err;
    logic prev;
    int n;
    a = 64'h2000;
    issue_cmd(a, 1'b1, 32'h1357_9bdf, 4'h5);
    check_bit("cache_cmd_valid", 1'b1, cap_cache_valid);
    check_addr("cache_cmd_addr", a, cap_cache_addr);
    check_bit("cache_cmd_read", 1'b1, cap_cache_read);
    check_word("cache_cmd_wdata", 32'h1357_9bdf, cap_cache_wdata);
    check_mask("cache_cmd_wmask", 4'h5, cap_cache_wmask);
    check_bit("cache_rsp_ready", 1'b1, cache_rsp_ready);
    check_bit("mem_cmd_valid", 1'b0, cap_mem_valid);
    release_cmd();
    n = 0;
    do begin
        @(posedge clk);
        n++;
    end while (!mem_cmd_valid && n < MAX_WAIT);
    if (!mem_cmd_valid) begin
        $display("error at %0t: cache refill never reached memory", $time);
        errors++;
    end
    check_addr("mem_cmd_addr", {a[63:3], 3'b000}, mem_cmd_addr);
    check_bit("mem_cmd_read", 1'b1, mem_cmd_read);
    check_beat("mem_cmd_wdata", {a[31:0], 32'hcafe_f00d}, mem_cmd_wdata);
    check_mask("mem_cmd_wmask", 4'hf, mem_cmd_wmask);
    wait_rsp(rd, err, prev);
    check_word("core_rsp_rdata", cache_word(a), rd);
    check_bit("core_rsp_err", 1'b0, err);
endtask

task automatic test_uncached_lanes();
    addr_t a;
    word_t rd;
    word_t exp;
    logic err;
    logic prev;
    for (int i = 0; i < 2; i++) begin
        a = (i == 0) ? 64'h8 : 64'hc;
        issue_cmd(a, 1'b1, '0, '0);
        check_bit("mem_cmd_valid", 1'b1, cap_mem_valid);
        check_addr("mem_cmd_addr", a, cap_mem_addr);
        release_cmd();
        wait_rsp(rd, err, prev);
        exp = lane_word(a);
        check_bit("mem_rsp_valid one cycle before", 1'b1, prev);
        check_word("core_rsp_rdata", exp, rd);
        check_bit("core_rsp_err", 1'b0, err);
    end
endtask

task automatic test_uncached_burst();
    addr_t list[6];
    for (int i = 0; i < 6; i++) begin
        list[i] = 64'(i * 4);
    end
    fork
        begin
            foreach (list[i]) begin
                issue_cmd(list[i], 1'b1, '0, '0);
            end
            release_cmd();
        end
        begin
            word_t rd;
            logic err;
            logic prev;
            foreach (list[i]) begin
                wait_rsp(rd, err, prev);
                check_word("core_rsp_rdata", lane_word(list[i]), rd);
            end
        end
    join
endtask

task automatic test_uncached_write();
    word_t rd;
    logic err;
    logic prev;
    issue_cmd(64'h10, 1'b0, 32'hdead_beef, 4'b0110);
    check_bit("mem_cmd_valid", 1'b1, cap_mem_valid);
    check_addr("mem_cmd_addr", 64'h10, cap_mem_addr);
    check_bit("mem_cmd_read", 1'b0, cap_mem_read);
    check_beat("mem_cmd_wdata", 64'h0000_0000_dead_beef, cap_mem_wdata);
    check_mask("mem_cmd_wmask", 4'b0110, cap_mem_wmask);
    release_cmd();
    wait_rsp(rd, err, prev);
    check_bit("core_rsp_err", 1'b0, err);
endtask

task automatic test_switch_drain();
    addr_t ca;
    addr_t ua;
    logic seen;
    int held;
    word_t rd;
    logic err;
    logic prev;
    ua = 64'h14;
    for (int r = 0; r < 2; r++) begin
        ca = 64'h3008 + 64'(r * 8);
        idle_first = (r == 1);  // second round drains the response last
        seen = 1'b0;
        held = 0;
        issue_cmd(ca, 1'b1, '0, '0);
        @(negedge clk);
        core_cmd_addr = ua;  // uncached command right behind the cached one
        forever begin
            @(posedge clk);
            if (core_rsp_valid) begin
                check_word("core_rsp_rdata", cache_word(ca), core_rsp_rdata);
                seen = 1'b1;
            end
            if (core_cmd_ready) begin
                break;
            end
            if (mem_cmd_valid && mem_cmd_addr == ua) begin
                $display("error at %0t: uncached command reached memory early", $time);
                errors++;
            end
            held++;
            if (held >= MAX_WAIT) begin
                $display("error at %0t: uncached command held forever", $time);
                errors++;
                break;
            end
        end
        if (!seen || !cache_idle || held == 0) begin
            $display("error at %0t: uncached command accepted before drain", $time);
            errors++;
        end
        check_addr("mem_cmd_addr", ua, mem_cmd_addr);
        release_cmd();
        wait_rsp(rd, err, prev);
        check_word("core_rsp_rdata", lane_word(ua), rd);
    end
    idle_first = 1'b0;
endtask

/* dv/tb_fetch_cache_front.sv */
`timescale 1ns/100ps

module tb_fetch_cache_front;

    import fetch_bus_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS  = 6;
    localparam int MAX_WAIT   = 100;  // cycles per handshake

    logic  clk;
    logic  rstn;
    logic  core_cmd_valid;
    logic  core_cmd_ready;
    addr_t core_cmd_addr;
    logic  core_cmd_read;
    word_t core_cmd_wdata;
    mask_t core_cmd_wmask;
    logic  core_rsp_valid;
    logic  core_rsp_ready;
    word_t core_rsp_rdata;
    logic  core_rsp_err;
    logic  cache_cmd_valid;
    logic  cache_cmd_ready;
    addr_t cache_cmd_addr;
    logic  cache_cmd_read;
    word_t cache_cmd_wdata;
    mask_t cache_cmd_wmask;
    logic  cache_rsp_valid;
    logic  cache_rsp_ready;
    word_t cache_rsp_rdata;
    logic  cache_rsp_err;
    logic  cache_idle;
    logic  cmem_cmd_valid;
    logic  cmem_cmd_ready;
    addr_t cmem_cmd_addr;
    logic  cmem_cmd_read;
    beat_t cmem_cmd_wdata;
    mask_t cmem_cmd_wmask;
    logic  cmem_rsp_valid;
    beat_t cmem_rsp_rdata;
    logic  cmem_rsp_err;
    logic  mem_cmd_valid;
    logic  mem_cmd_ready;
    addr_t mem_cmd_addr;
    logic  mem_cmd_read;
    beat_t mem_cmd_wdata;
    mask_t mem_cmd_wmask;
    logic  mem_rsp_valid;
    beat_t mem_rsp_rdata;
    logic  mem_rsp_err;

    int          errors;
    logic [31:0] lcg_state;
    int          cyc;
    int          last_due;
    logic        idle_first;  // cache model ends its burst before the response
    addr_t       mq_addr[$];
    int          mq_due[$];

    fetch_cache_front DUT (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    // expected data, derived from the address only
    function automatic word_t cache_word(addr_t a);
        return a[31:0] ^ 32'h00c0_ffee;
    endfunction

    function automatic beat_t mem_beat(addr_t a);
        return {a[31:0] ^ 32'h5a5a_0000, ~a[31:0]};
    endfunction

    // bit 2 picks the upper half of the beat
    function automatic word_t lane_word(addr_t a);
        beat_t b;
        b = mem_beat(a);
        return a[2] ? b[63:32] : b[31:0];
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    `include "tb_tasks.svh"

    //////////////////////////////////////////////////////////////////////
    // cache core model, one command at a time
    //////////////////////////////////////////////////////////////////////

    initial begin
        addr_t a;
        forever begin
            @(posedge clk);
            if (cache_cmd_valid && cache_cmd_ready) begin
                a = cache_cmd_addr;
                @(negedge clk);
                cache_idle     = 1'b0;
                cmem_cmd_valid = 1'b1;
                cmem_cmd_addr  = {a[63:3], 3'b000};  // refill beat
                cmem_cmd_read  = 1'b1;
                cmem_cmd_wdata = {a[31:0], 32'hcafe_f00d};
                cmem_cmd_wmask = 4'hf;
                do @(posedge clk); while (!cmem_cmd_ready);
                @(negedge clk);
                cmem_cmd_valid = 1'b0;
                do @(posedge clk); while (!cmem_rsp_valid);
                check_beat("cmem_rsp_rdata", mem_beat({a[63:3], 3'b000}), cmem_rsp_rdata);
                check_bit("cmem_rsp_err", 1'b0, cmem_rsp_err);
                @(negedge clk);
                if (idle_first) begin
                    cache_idle = 1'b1;  // refill done, word comes later
                    repeat (2) @(negedge clk);
                end
                cache_rsp_valid = 1'b1;
                cache_rsp_rdata = cache_word(a);
                @(negedge clk);
                cache_rsp_valid = 1'b0;
                repeat (3) @(negedge clk);
                cache_idle = 1'b1;  // refill tail ends three cycles later
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // memory model, in order, random latency
    //////////////////////////////////////////////////////////////////////

    initial begin
        int due;
        forever begin
            @(posedge clk);
            cyc = cyc + 1;
            if (mem_cmd_valid && mem_cmd_ready) begin
                due = cyc + 1 + int'((lcg_next() >> 16) % 4);
                if (mq_due.size() > 0 && due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                mq_addr.push_back(mem_cmd_addr);
                mq_due.push_back(due);
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            mem_rsp_valid = 1'b0;
            if (mq_due.size() > 0 && cyc >= mq_due[0]) begin
                void'(mq_due.pop_front());
                mem_rsp_rdata = mem_beat(mq_addr.pop_front());
                mem_rsp_valid = 1'b1;
                mem_rsp_err   = 1'b0;
            end
        end
    end

    initial begin
        #((NUM_TESTS * 200 + 20) * CLK_PERIOD);
        $display("timeout at %0t: tests did not finish", $time);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        errors = 0;
        lcg_state = 32'h272c;
        cyc = 0;
        last_due = 0;
        idle_first = 1'b0;
        core_cmd_valid = 1'b0;
        core_cmd_addr = '0;
        core_cmd_read = 1'b0;
        core_cmd_wdata = '0;
        core_cmd_wmask = '0;
        core_rsp_ready = 1'b1;  // held high, uncached path ignores it
        cache_cmd_ready = 1'b1;
        cache_rsp_valid = 1'b0;
        cache_rsp_rdata = '0;
        cache_rsp_err = 1'b0;
        cache_idle = 1'b1;
        cmem_cmd_valid = 1'b0;
        cmem_cmd_addr = '0;
        cmem_cmd_read = 1'b0;
        cmem_cmd_wdata = '0;
        cmem_cmd_wmask = '0;
        mem_cmd_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp_rdata = '0;
        mem_rsp_err = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        test_reset_idle();
        test_cached_read();
        test_uncached_lanes();
        test_uncached_burst();
        test_uncached_write();
        test_switch_drain();
        repeat (5) @(posedge clk);

        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+dv
hdl/fetch_bus_pkg.sv
hdl/route_pkg.sv
hdl/path_router.sv
hdl/uncached_lane_fifo.sv
hdl/bus_merge.sv
hdl/fetch_cache_front.sv
dv/tb_fetch_cache_front.sv
